// File: flist.f
+incdir+.
xor_fabric_pkg.sv
window_shifter.sv
delay_line.sv
count_offset.sv
word_transform.sv
lane_array.sv
xor_fabric_top.sv
tb_clock_gen.sv
xor_fabric_asserts.sv
xor_fabric_tb.sv

// File: Makefile
# Verilator build and run for the XOR fabric testbench

VERILATOR ?= verilator
TOP       ?= xor_fabric_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := Done: errors found
PASS_MSG := Done: no errors
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FLIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended without a result"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: xor_fabric_tb.sv
/*
 * Testbench for xor_fabric_top: zero fill, one impulse word, then random words.
 * A cycle model built from the lane rules predicts out, which is compared
 * on every falling edge. Stops at the first mismatch.
 */
`default_nettype none

`include "xor_fabric_defines.svh"

module xor_fabric_tb
	import xor_fabric_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD    = 20;
	localparam int RESET_CYCLES  = 10;
	localparam int SEED          = 14659;
	localparam int ZERO_CYCLES   = 30;
	localparam int GAP_CYCLES    = 30;
	localparam int RANDOM_CYCLES = 2000;
	localparam int MAX_LATENCY   = 13;
	localparam int DRAIN_CYCLES  = MAX_LATENCY + 7;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + ZERO_CYCLES + 1 + GAP_CYCLES
		+ RANDOM_CYCLES + DRAIN_CYCLES + MAX_LATENCY + 100;
	localparam int HALF = `WORD_WIDTH / 2;
	localparam word_t IMPULSE_WORD = 32'hc5a3_1e7b;

	logic  clk;
	logic  rst;
	word_t in;
	word_t out;

	// model state
	word_t  m_win [4];
	word_t  m_cap [4];
	word_t  m_l0_d1, m_l0_cnt, m_l0_out;
	word_t  m_l0_r4 [`SHIFT_DEPTH];
	word_t  m_l1_cnt, m_l1_d1, m_l1_dec, m_l1_out;
	word_t  m_l2_cnt;
	word_t  m_l2_r8 [`RAM_DEPTH];
	word_t  m_l2_r4 [`SHIFT_DEPTH];
	word_t  m_l3_as, m_l3_par, m_l3_out;
	word_t  m_l3_r4 [`SHIFT_DEPTH];
	count_t m_count;
	int     m_p4;
	int     m_p8;
	word_t  exp_out;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clock_gen_i (
		.clk (clk),
		.rst (rst)
	);

	xor_fabric_top xor_fabric_top_i (
		.clk (clk),
		.rst (rst),
		.in  (in),
		.out (out)
	);

	function automatic word_t decode_word(input word_t x);
		word_t r;
		r = '0;
		r[x[`DECODE_BITS-1:0]] = 1'b1;
		return r;
	endfunction

	function automatic word_t fold_add(input word_t x);
		return word_t'(x[HALF-1:0]) + word_t'(x[`WORD_WIDTH-1:HALF]);
	endfunction

	function automatic word_t add_sub(input word_t x);
		logic [HALF-1:0] lo;
		logic [HALF-1:0] b;
		logic [HALF-1:0] r;
		lo = x[HALF-1:0];
		b = {1'b0, x[`WORD_WIDTH-2:HALF]};
		if (x[`WORD_WIDTH-1]) begin
			r = lo - b;
		end else begin
			r = lo + b;
		end
		return word_t'(r);
	endfunction

	function automatic word_t parity_word(input word_t x);
		logic p;
		p = 1'b0;
		for (int i = 0; i < `WORD_WIDTH - 1; i++) begin
			p = p ^ x[i];
		end
		return {p, x[`WORD_WIDTH-2:0]};
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s actual 0x%08h expected 0x%08h",
				$time, name, actual, expected);
			$display("Done: errors found");
			$fatal(1, "output mismatch");
		end
	endtask

	task reset_model();
		for (int i = 0; i < 4; i++) begin
			m_win[i] = '0;
			m_cap[i] = '0;
		end
		for (int i = 0; i < `SHIFT_DEPTH; i++) begin
			m_l0_r4[i] = '0;
			m_l2_r4[i] = '0;
			m_l3_r4[i] = '0;
		end
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			m_l2_r8[i] = '0;
		end
		{m_l0_d1, m_l0_cnt, m_l0_out} = '0;
		{m_l1_cnt, m_l1_d1, m_l1_dec, m_l1_out} = '0;
		{m_l2_cnt, m_l3_as, m_l3_par, m_l3_out} = '0;
		m_count = '0;
		m_p4 = 0;
		m_p8 = 0;
		exp_out = '0;
	endtask

	// stages updated from the end of each chain so each reads last cycle's value
	task step_model(input word_t din);
		m_l0_out = decode_word(m_l0_cnt);
		m_l0_cnt = m_l0_r4[m_p4] + word_t'(m_count);
		m_l0_r4[m_p4] = m_l0_d1;
		m_l0_d1 = m_cap[0];
		m_l1_out = fold_add(m_l1_dec);
		m_l1_dec = decode_word(m_l1_d1);
		m_l1_d1 = m_l1_cnt;
		m_l1_cnt = m_cap[1] + word_t'(m_count);
		m_l2_r4[m_p4] = m_l2_r8[m_p8];
		m_l2_r8[m_p8] = m_l2_cnt;
		m_l2_cnt = m_cap[2] + word_t'(m_count);
		m_l3_out = fold_add(m_l3_par);
		m_l3_par = parity_word(m_l3_r4[m_p4]);
		m_l3_r4[m_p4] = m_l3_as;
		m_l3_as = add_sub(m_cap[3]);
		for (int i = 0; i < 4; i++) begin
			m_cap[i] = m_win[i];
		end
		m_win[3] = m_win[2];
		m_win[2] = m_win[1];
		m_win[1] = m_win[0];
		m_win[0] = din;
		m_count = (m_count == count_t'(`COUNT_MOD - 1)) ? '0 : m_count + count_t'(1);
		m_p4 = (m_p4 + 1) % `SHIFT_DEPTH;
		m_p8 = (m_p8 + 1) % `RAM_DEPTH;
		exp_out = m_l0_out ^ m_l1_out ^ m_l2_r4[m_p4] ^ m_l3_out;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			reset_model();
		end else begin
			step_model(in);
		end
	end

	always @(negedge clk) begin
		check_value("out", out, exp_out);
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

	initial begin
		void'($urandom(SEED));
		in = '0;
		@(negedge rst);
		// zero input shows the counter offsets alone
		repeat (ZERO_CYCLES) begin
			@(posedge clk);
			in <= '0;
		end
		@(posedge clk);
		in <= IMPULSE_WORD;
		repeat (GAP_CYCLES) begin
			@(posedge clk);
			in <= '0;
		end
		repeat (RANDOM_CYCLES) begin
			@(posedge clk);
			in <= $urandom();
		end
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			in <= '0;
		end
		@(posedge clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: xor_fabric_asserts.sv
/*
 * Concurrent checks bound into xor_fabric_top.
 * The lane 2 check waits until 14 edges after reset so that its history is valid.
 */
`default_nettype none

module xor_fabric_asserts import xor_fabric_pkg::*; (
	input logic   clk,
	input logic   rst,
	input word_t  out,
	input word_t  lanes_w2,
	input word_t  results_w2,
	input count_t count_val,
	input word_t  parity_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// edges since reset, saturating
	logic [3:0] settle;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			settle <= '0;
		end else if (settle != 4'hf) begin
			settle <= settle + 4'd1;
		end
	end

	// decode stages turn non-zero one edge after release
	a_reset_zero: assert property (@(posedge clk) $past(rst) |-> out == '0)
	else $error("out not zero after a reset edge");

	// count offset, then 8 and 4 deep delays
	a_lane2_chain: assert property (@(posedge clk) disable iff (rst)
		(settle >= 4'd14) |-> results_w2 == $past(lanes_w2 + word_t'(count_val), 13))
	else $error("lane 2 result does not match its delayed input");

	a_parity_even: assert property (@(posedge clk) disable iff (rst)
		(^parity_out) == 1'b0)
	else $error("lane 3 parity word has odd parity");

endmodule

bind xor_fabric_top xor_fabric_asserts xor_fabric_asserts_i (
	.clk        (clk),
	.rst        (rst),
	.out        (out),
	.lanes_w2   (lanes.w2),
	.results_w2 (results.w2),
	.count_val  (lane_array_i.lane2_cnt_i.count),
	.parity_out (lane_array_i.lane3_par)
);

`default_nettype wire

// File: tb_clock_gen.sv
/*
 * Testbench clock and reset source. rst starts high and is released
 * on a rising edge after RESET_CYCLES edges.
 */
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

// File: xor_fabric_top.sv
/*
 * Window shifter feeding four lane pipelines. out is the XOR of the lane results.
 * No handshake: in is sampled every cycle, and out is zero straight after reset.
 */
`default_nettype none

module xor_fabric_top import xor_fabric_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t in,
	output word_t out
);

	lane_bus_t lanes;
	lane_bus_t results;

	window_shifter window_shifter_i (
		.clk   (clk),
		.rst   (rst),
		.in    (in),
		.lanes (lanes)
	);

	lane_array lane_array_i (
		.clk     (clk),
		.rst     (rst),
		.lanes   (lanes),
		.results (results)
	);

	// combinational, straight from the lane registers
	assign out = results.w0 ^ results.w1 ^ results.w2 ^ results.w3;

endmodule

`default_nettype wire

// File: lane_array.sv
/*
 * Four fixed lane pipelines, lanes.wN to results.wN.
 * Latencies are 7, 4, 13 and 7 cycles. Every stage advances every cycle.
 */
`default_nettype none

`include "xor_fabric_defines.svh"

module lane_array import xor_fabric_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  lane_bus_t lanes,
	output lane_bus_t results
);

	word_t lane0_d1;
	word_t lane0_d4;
	word_t lane0_cnt;
	word_t lane0_out;

	word_t lane1_cnt;
	word_t lane1_d1;
	word_t lane1_dec;
	word_t lane1_out;

	word_t lane2_cnt;
	word_t lane2_d8;
	word_t lane2_out;

	word_t lane3_as;
	word_t lane3_d4;
	word_t lane3_par;
	word_t lane3_out;

	// lane 0
	delay_line #(.DEPTH(1)) lane0_reg_i (
		.clk(clk), .rst(rst), .data_in(lanes.w0), .data_out(lane0_d1)
	);
	delay_line #(.DEPTH(`SHIFT_DEPTH)) lane0_shift_i (
		.clk(clk), .rst(rst), .data_in(lane0_d1), .data_out(lane0_d4)
	);
	count_offset lane0_cnt_i (
		.clk(clk), .rst(rst), .data_in(lane0_d4), .data_out(lane0_cnt)
	);
	word_transform #(.OP(OP_DECODE)) lane0_dec_i (
		.clk(clk), .rst(rst), .data_in(lane0_cnt), .data_out(lane0_out)
	);

	// lane 1
	count_offset lane1_cnt_i (
		.clk(clk), .rst(rst), .data_in(lanes.w1), .data_out(lane1_cnt)
	);
	delay_line #(.DEPTH(1)) lane1_reg_i (
		.clk(clk), .rst(rst), .data_in(lane1_cnt), .data_out(lane1_d1)
	);
	word_transform #(.OP(OP_DECODE)) lane1_dec_i (
		.clk(clk), .rst(rst), .data_in(lane1_d1), .data_out(lane1_dec)
	);
	word_transform #(.OP(OP_FOLD_ADD)) lane1_fold_i (
		.clk(clk), .rst(rst), .data_in(lane1_dec), .data_out(lane1_out)
	);

	// lane 2, no latch stage
	count_offset lane2_cnt_i (
		.clk(clk), .rst(rst), .data_in(lanes.w2), .data_out(lane2_cnt)
	);
	delay_line #(.DEPTH(`RAM_DEPTH)) lane2_ram_i (
		.clk(clk), .rst(rst), .data_in(lane2_cnt), .data_out(lane2_d8)
	);
	delay_line #(.DEPTH(`SHIFT_DEPTH)) lane2_shift_i (
		.clk(clk), .rst(rst), .data_in(lane2_d8), .data_out(lane2_out)
	);

	// lane 3
	word_transform #(.OP(OP_ADD_SUB)) lane3_as_i (
		.clk(clk), .rst(rst), .data_in(lanes.w3), .data_out(lane3_as)
	);
	delay_line #(.DEPTH(`SHIFT_DEPTH)) lane3_shift_i (
		.clk(clk), .rst(rst), .data_in(lane3_as), .data_out(lane3_d4)
	);
	word_transform #(.OP(OP_PARITY)) lane3_par_i (
		.clk(clk), .rst(rst), .data_in(lane3_d4), .data_out(lane3_par)
	);
	word_transform #(.OP(OP_FOLD_ADD)) lane3_fold_i (
		.clk(clk), .rst(rst), .data_in(lane3_par), .data_out(lane3_out)
	);

	assign results = '{
		w0: lane0_out,
		w1: lane1_out,
		w2: lane2_out,
		w3: lane3_out
	};

endmodule

`default_nettype wire

// File: word_transform.sv
/*
 * Registered word operation picked at elaboration by OP.
 * Fold-add gives 17 significant bits, add/sub wraps to 16 bits, both zero-extended.
 * Parity sets bit 31 so that the whole word has even parity.
 */
`default_nettype none

`include "xor_fabric_defines.svh"

module word_transform import xor_fabric_pkg::*; #(
	parameter transform_op_e OP = OP_DECODE
) (
	input  logic  clk,
	input  logic  rst,
	input  word_t data_in,
	output word_t data_out
);

	localparam int HALF = `WORD_WIDTH / 2;

	logic [HALF-1:0] lo_half;
	logic [HALF-1:0] hi_half;
	logic [HALF:0]   fold_sum;
	logic [HALF-1:0] as_operand;
	logic [HALF-1:0] as_result;
	logic            sub_sel;
	word_t           result;

	assign lo_half = data_in[HALF-1:0];
	assign hi_half = data_in[`WORD_WIDTH-1:HALF];

	// unsigned halves, carry kept
	assign fold_sum = {1'b0, lo_half} + {1'b0, hi_half};

	// top bit picks subtract, bits 30..16 are the operand
	assign sub_sel = data_in[`WORD_WIDTH-1];
	assign as_operand = {1'b0, data_in[`WORD_WIDTH-2:HALF]};
	assign as_result = sub_sel ? (lo_half - as_operand) : (lo_half + as_operand);

	always_comb begin
		case (OP)
			OP_DECODE: begin
				result = word_t'(1) << data_in[`DECODE_BITS-1:0];
			end
			OP_FOLD_ADD: begin
				result = word_t'(fold_sum);
			end
			OP_ADD_SUB: begin
				result = word_t'(as_result);
			end
			OP_PARITY: begin
				result = {^data_in[`WORD_WIDTH-2:0], data_in[`WORD_WIDTH-2:0]};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_out <= '0;
		end else begin
			data_out <= result;
		end
	end

endmodule

`default_nettype wire

// File: count_offset.sv
/*
 * Adds a free-running modulo COUNT_MOD count to each word, one cycle latency.
 * The count is 0 on the first cycle after reset. The sum wraps at the word width.
 */
`default_nettype none

`include "xor_fabric_defines.svh"

module count_offset import xor_fabric_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  word_t data_in,
	output word_t data_out
);

	count_t count;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			count <= '0;
		end else if (count == count_t'(`COUNT_MOD - 1)) begin
			count <= '0;
		end else begin
			count <= count + count_t'(1);
		end
	end

	// count zero-extended before the add
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_out <= '0;
		end else begin
			data_out <= data_in + word_t'(count);
		end
	end

endmodule

`default_nettype wire

// File: delay_line.sv
/*
 * Fixed delay of DEPTH cycles built as a ring buffer, DEPTH >= 1.
 * The ring is cleared by reset, so zeros come out until it has filled.
 * DEPTH 1 gives a plain register.
 */
`default_nettype none

module delay_line import xor_fabric_pkg::*; #(
	parameter int DEPTH = 1
) (
	input  logic  clk,
	input  logic  rst,
	input  word_t data_in,
	output word_t data_out
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	typedef logic [PTR_W-1:0] ptr_t;

	word_t ring [DEPTH];
	ptr_t  wr_ptr;

	// slot under the pointer holds the oldest word
	assign data_out = ring[wr_ptr];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_ptr == ptr_t'(DEPTH - 1)) begin
			wr_ptr <= '0;
		end else begin
			wr_ptr <= wr_ptr + ptr_t'(1);
		end
	end

	// oldest slot is read out and overwritten on the same edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				ring[i] <= '0;
			end
		end else begin
			ring[wr_ptr] <= data_in;
		end
	end

	initial begin
		assert (DEPTH >= 1)
		else $error("delay_line DEPTH must be at least 1");
	end

endmodule

`default_nettype wire

// File: window_shifter.sv
/*
 * Four-word window of the input stream with a capture register behind it.
 * Input is sampled on every edge. A word reaches lanes.wN after N+2 edges.
 */
`default_nettype none

module window_shifter import xor_fabric_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  word_t     in,
	output lane_bus_t lanes
);

	// slot 0 is the newest word
	lane_bus_t window;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			window <= '0;
		end else begin
			window <= '{
				w0: in,
				w1: window.w0,
				w2: window.w1,
				w3: window.w2
			};
		end
	end

	// snapshot of the previous window, one word per lane
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lanes <= '0;
		end else begin
			lanes <= window;
		end
	end

endmodule

`default_nettype wire

// File: xor_fabric_pkg.sv
/*
 * Types shared by the fabric. Widths come from the defines header.
 * lane_bus_t puts w0 in the top bits of the packed struct.
 */
`default_nettype none

`include "xor_fabric_defines.svh"

package xor_fabric_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t;

	typedef logic [`COUNT_WIDTH-1:0] count_t;

	// one word per lane
	typedef struct packed {
		word_t w0;
		word_t w1;
		word_t w2;
		word_t w3;
	} lane_bus_t;

	// word_transform operations
	typedef enum logic [1:0] {
		OP_DECODE,
		OP_FOLD_ADD,
		OP_ADD_SUB,
		OP_PARITY
	} transform_op_e;

endpackage

`default_nettype wire

// File: xor_fabric_defines.svh
/*
 * Shared widths, delay depths and counter modulus for the XOR fabric.
 * COUNT_WIDTH must hold COUNT_MOD-1, and DECODE_BITS must be log2 of WORD_WIDTH.
 */
`ifndef XOR_FABRIC_DEFINES_SVH
`define XOR_FABRIC_DEFINES_SVH

// data word
`define WORD_WIDTH 32

// short and long fixed delays, in cycles
`define SHIFT_DEPTH 4
`define RAM_DEPTH 8

// counter wraps from COUNT_MOD-1 to 0
`define COUNT_MOD 10
`define COUNT_WIDTH 4

// low input bits used by the one-hot decode
`define DECODE_BITS 5

`endif
